// ==== compile.f ====
+incdir+include
logic/csr_pkg.sv
logic/csr_if.sv
logic/csr_access_decode.sv
logic/csr_trap_regs.sv
logic/csr_config_regs.sv
logic/csr_read_resp.sv
logic/csr_top.sv
verif/csr_tb.sv

// ==== include/csr_macros.svh ====
// Machine CSR block constants
// Register width, CSR addresses, reset values and the mtvec alignment rule

`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN            32
`define CSR_ADDR_W          12

// Machine CSR addresses --------------------------
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

// Reset and constant values ----------------------
`define CSR_MTVEC_RESET     32'hC000_0000   // Direct mode
`define CSR_MTVEC_ALIGN     7               // Vectored base alignment
`define CSR_MISA_VALUE      32'h4000_1100   // MXL=32, I and M

`endif

// ==== logic/csr_access_decode.sv ====
// CSR access decoder
// Turns the address and strobes into one-hot read and write selects

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_access_decode (
    input  logic                    csr_en,
    input  logic                    csr_wr,
    input  logic                    csr_wr_set,
    input  logic                    csr_wr_clr,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    csr_wdata,
    csr_wr_if.source                wr,
    output csr_pkg::csr_sel_t       rd_sel,
    output logic                    addr_valid
);

    csr_pkg::csr_sel_t hit;     // Raw address match
    logic              wr_en;

    always_comb begin
        hit.mstatus   = csr_addr == `CSR_ADDR_MSTATUS;
        hit.misa      = csr_addr == `CSR_ADDR_MISA;
        hit.medeleg   = csr_addr == `CSR_ADDR_MEDELEG;
        hit.mideleg   = csr_addr == `CSR_ADDR_MIDELEG;
        hit.mie       = csr_addr == `CSR_ADDR_MIE;
        hit.mtvec     = csr_addr == `CSR_ADDR_MTVEC;
        hit.mscratch  = csr_addr == `CSR_ADDR_MSCRATCH;
        hit.mepc      = csr_addr == `CSR_ADDR_MEPC;
        hit.mcause    = csr_addr == `CSR_ADDR_MCAUSE;
        hit.mtval     = csr_addr == `CSR_ADDR_MTVAL;
        hit.mip       = csr_addr == `CSR_ADDR_MIP;
        hit.mvendorid = csr_addr == `CSR_ADDR_MVENDORID;
        hit.marchid   = csr_addr == `CSR_ADDR_MARCHID;
        hit.mimpid    = csr_addr == `CSR_ADDR_MIMPID;
        hit.mhartid   = csr_addr == `CSR_ADDR_MHARTID;
    end

    assign wr_en = csr_en & csr_wr;

    // Gated selects --------------------------------
    assign rd_sel   = csr_pkg::csr_sel_t'(hit & {$bits(hit){csr_en}});
    assign wr.sel   = csr_pkg::csr_sel_t'(hit & {$bits(hit){wr_en}});
    assign wr.wdata = csr_wdata;
    assign wr.set   = csr_wr_set;
    assign wr.clr   = csr_wr_clr;

    assign addr_valid = |hit;   // Names an implemented CSR

endmodule

// ==== logic/csr_config_regs.sv ====
// Configuration register bank
// mie enables, mtvec with its legality check, and mscratch

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_config_regs (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    csr_wr_if.sink                wr,
    output logic                  mie_meie,
    output logic                  mie_mtie,
    output logic                  mie_msie,
    output logic [`CSR_XLEN-1:0]  mtvec,
    output logic [`CSR_XLEN-1:0]  mscratch,
    output logic                  mtvec_bad
);

    logic [`CSR_XLEN-1:0] mie_img;
    logic [`CSR_XLEN-1:0] n_mie;
    logic [`CSR_XLEN-1:0] n_mtvec;
    logic                 mtvec_illegal;

    // mie --------------------------------------------
    assign mie_img = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    assign n_mie   = csr_pkg::csr_combine(mie_img, wr.wdata, wr.set, wr.clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_meie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_msie <= 1'b0;
        end else if (wr.sel.mie) begin
            mie_meie <= n_mie[11];
            mie_mtie <= n_mie[7];
            mie_msie <= n_mie[3];
        end
    end

    // mtvec ------------------------------------------
    assign n_mtvec = csr_pkg::csr_combine(mtvec, wr.wdata, wr.set, wr.clr);

    // Mode 2 and 3 reserved, vectored base must be aligned
    assign mtvec_illegal = n_mtvec[1] |
                           (n_mtvec[0] & (|n_mtvec[`CSR_MTVEC_ALIGN-1:2]));
    assign mtvec_bad     = wr.sel.mtvec & mtvec_illegal;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec <= `CSR_MTVEC_RESET;
        end else if (wr.sel.mtvec && !mtvec_illegal) begin
            mtvec <= n_mtvec;
        end
    end

    // mscratch ---------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
        end else if (wr.sel.mscratch) begin
            mscratch <= csr_pkg::csr_combine(mscratch, wr.wdata, wr.set, wr.clr);
        end
    end

endmodule

// ==== logic/csr_if.sv ====
// CSR block interfaces
// Software write bus from the decoder and trap event bus into the trap bank

`timescale 1ns/1ps
`include "csr_macros.svh"

interface csr_wr_if;
    csr_pkg::csr_sel_t       sel;    // One-hot write strobes
    logic [`CSR_XLEN-1:0]    wdata;
    logic                    set;    // Set-bit operation
    logic                    clr;    // Clear-bit operation

    modport source (
        output sel,
        output wdata,
        output set,
        output clr
    );

    modport sink (
        input  sel,
        input  wdata,
        input  set,
        input  clr
    );
endinterface

interface csr_trap_if;
    logic                    trap_cpu;   // Exception pulse
    logic                    trap_int;   // Interrupt pulse
    csr_pkg::trap_code_e     cause;
    logic [`CSR_XLEN-1:0]    mtval;
    logic [`CSR_XLEN-1:0]    pc;
    logic                    mret;       // MRET pulse

    modport sink (
        input  trap_cpu,
        input  trap_int,
        input  cause,
        input  mtval,
        input  pc,
        input  mret
    );
endinterface

// ==== logic/csr_pkg.sv ====
// CSR package
// Register select struct, legal exception codes and the write-combine rule

`include "csr_macros.svh"

package csr_pkg;

    // One select bit per implemented register
    typedef struct packed {
        logic mstatus;
        logic misa;
        logic medeleg;
        logic mideleg;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mip;
        logic mvendorid;
        logic marchid;
        logic mimpid;
        logic mhartid;
    } csr_sel_t;

    // Legal synchronous exception codes
    typedef enum logic [6:0] {
        TRAP_IALIGN   = 7'd0,   // Instruction misaligned
        TRAP_IACCESS  = 7'd1,   // Instruction access fault
        TRAP_IOPCODE  = 7'd2,   // Illegal opcode
        TRAP_BREAKPT  = 7'd3,
        TRAP_LDALIGN  = 7'd4,
        TRAP_LDACCESS = 7'd5,
        TRAP_STALIGN  = 7'd6,
        TRAP_STACCESS = 7'd7,
        TRAP_ECALLM   = 7'd11   // Environment call from M-mode
    } trap_code_e;

    // New value of a register under write, set or clear
    function automatic logic [`CSR_XLEN-1:0] csr_combine(
        input logic [`CSR_XLEN-1:0] old_val,
        input logic [`CSR_XLEN-1:0] wdata,
        input logic                 set,
        input logic                 clr
    );
        if (set) begin
            return old_val | wdata;
        end else if (clr) begin
            return old_val & ~wdata;
        end
        return wdata;
    endfunction

endpackage

// ==== logic/csr_read_resp.sv ====
// CSR read responder
// Selects the read data and flags bad write accesses

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_read_resp (
    input  csr_pkg::csr_sel_t     rd_sel,
    input  logic                  addr_valid,
    input  logic                  csr_wr,
    input  logic                  mstatus_mie,
    input  logic                  mstatus_mpie,
    input  logic [`CSR_XLEN-1:0]  mepc,
    input  logic [`CSR_XLEN-1:0]  mcause,
    input  logic [`CSR_XLEN-1:0]  mtval,
    input  logic                  mie_meie,
    input  logic                  mie_mtie,
    input  logic                  mie_msie,
    input  logic [`CSR_XLEN-1:0]  mtvec,
    input  logic [`CSR_XLEN-1:0]  mscratch,
    input  logic                  mtvec_bad,
    input  logic                  mip_meip,
    input  logic                  mip_mtip,
    input  logic                  mip_msip,
    output logic [`CSR_XLEN-1:0]  csr_rdata,
    output logic                  csr_error
);

    logic [`CSR_XLEN-1:0] mstatus_img;
    logic [`CSR_XLEN-1:0] mie_img;
    logic [`CSR_XLEN-1:0] mip_img;

    assign mstatus_img = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie_img     = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    assign mip_img     = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};

    // ID registers, medeleg and mideleg add nothing
    assign csr_rdata =
        ({`CSR_XLEN{rd_sel.mstatus}}  & mstatus_img)     |
        ({`CSR_XLEN{rd_sel.misa}}     & `CSR_MISA_VALUE) |
        ({`CSR_XLEN{rd_sel.mie}}      & mie_img)         |
        ({`CSR_XLEN{rd_sel.mtvec}}    & mtvec)           |
        ({`CSR_XLEN{rd_sel.mscratch}} & mscratch)        |
        ({`CSR_XLEN{rd_sel.mepc}}     & mepc)            |
        ({`CSR_XLEN{rd_sel.mcause}}   & mcause)          |
        ({`CSR_XLEN{rd_sel.mtval}}    & mtval)           |
        ({`CSR_XLEN{rd_sel.mip}}      & mip_img);

    assign csr_error = (csr_wr & ~addr_valid) | mtvec_bad;

endmodule

// ==== logic/csr_top.sv ====
// Machine-mode CSR block
// Decoder, trap and configuration banks and read responder behind plain ports

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_top (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    csr_en,
    input  logic                    csr_wr,
    input  logic                    csr_wr_set,
    input  logic                    csr_wr_clr,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    csr_wdata,
    input  logic                    exec_mret,
    input  logic                    mip_meip,
    input  logic                    mip_mtip,
    input  logic                    mip_msip,
    input  logic                    trap_cpu,
    input  logic                    trap_int,
    input  logic [6:0]              trap_cause,
    input  logic [`CSR_XLEN-1:0]    trap_mtval,
    input  logic [`CSR_XLEN-1:0]    trap_pc,
    output logic [`CSR_XLEN-1:0]    csr_rdata,
    output logic                    csr_error,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output logic [`CSR_XLEN-1:0]    mtvec_base,
    output logic [1:0]              mtvec_mode,
    output logic                    mstatus_mie,
    output logic                    mie_meie,
    output logic                    mie_mtie,
    output logic                    mie_msie
);

    csr_wr_if   wr_bus ();
    csr_trap_if trap_bus ();

    csr_pkg::csr_sel_t    rd_sel;
    logic                 addr_valid;
    logic                 sw_write;     // Enabled software write
    logic                 mstatus_mpie;
    logic                 mtvec_bad;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;

    // Trap event bus ---------------------------------
    assign trap_bus.trap_cpu = trap_cpu;
    assign trap_bus.trap_int = trap_int;
    assign trap_bus.cause    = csr_pkg::trap_code_e'(trap_cause);
    assign trap_bus.mtval    = trap_mtval;
    assign trap_bus.pc       = trap_pc;
    assign trap_bus.mret     = exec_mret;

    assign sw_write   = csr_en & csr_wr;

    assign mtvec_base = {mtvec[`CSR_XLEN-1:2], 2'b00};
    assign mtvec_mode = mtvec[1:0];

    csr_access_decode u_decode (
        .csr_en     (csr_en),
        .csr_wr     (csr_wr),
        .csr_wr_set (csr_wr_set),
        .csr_wr_clr (csr_wr_clr),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .wr         (wr_bus.source),
        .rd_sel     (rd_sel),
        .addr_valid (addr_valid)
    );

    csr_trap_regs u_trap_regs (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .wr           (wr_bus.sink),
        .trap         (trap_bus.sink),
        .mstatus_mie  (mstatus_mie),
        .mstatus_mpie (mstatus_mpie),
        .mepc_fwd     (csr_mepc),
        .mepc         (mepc),
        .mcause       (mcause),
        .mtval        (mtval)
    );

    csr_config_regs u_config_regs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wr        (wr_bus.sink),
        .mie_meie  (mie_meie),
        .mie_mtie  (mie_mtie),
        .mie_msie  (mie_msie),
        .mtvec     (mtvec),
        .mscratch  (mscratch),
        .mtvec_bad (mtvec_bad)
    );

    csr_read_resp u_read_resp (
        .rd_sel       (rd_sel),
        .addr_valid   (addr_valid),
        .csr_wr       (sw_write),
        .mstatus_mie  (mstatus_mie),
        .mstatus_mpie (mstatus_mpie),
        .mepc         (mepc),
        .mcause       (mcause),
        .mtval        (mtval),
        .mie_meie     (mie_meie),
        .mie_mtie     (mie_mtie),
        .mie_msie     (mie_msie),
        .mtvec        (mtvec),
        .mscratch     (mscratch),
        .mtvec_bad    (mtvec_bad),
        .mip_meip     (mip_meip),
        .mip_mtip     (mip_mtip),
        .mip_msip     (mip_msip),
        .csr_rdata    (csr_rdata),
        .csr_error    (csr_error)
    );

endmodule

// ==== logic/csr_trap_regs.sv ====
// Trap register bank
// mstatus, mepc, mcause and mtval, updated by software writes and trap events

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_trap_regs (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    csr_wr_if.sink                wr,
    csr_trap_if.sink              trap,
    output logic                  mstatus_mie,
    output logic                  mstatus_mpie,
    output logic [`CSR_XLEN-1:0]  mepc_fwd,
    output logic [`CSR_XLEN-1:0]  mepc,
    output logic [`CSR_XLEN-1:0]  mcause,
    output logic [`CSR_XLEN-1:0]  mtval
);

    logic                 trap_any;
    logic [`CSR_XLEN-1:0] mstatus_img;
    logic [`CSR_XLEN-1:0] n_mstatus;
    logic [`CSR_XLEN-1:0] n_mepc;
    logic                 wen_mepc;
    logic                 mcause_legal;

    assign trap_any = trap.trap_int | trap.trap_cpu;

    // mstatus ----------------------------------------
    assign mstatus_img = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign n_mstatus   = csr_pkg::csr_combine(mstatus_img, wr.wdata, wr.set, wr.clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (trap_any) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= mstatus_mie;     // Save enable on entry
        end else if (trap.mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b0;
        end else if (wr.sel.mstatus) begin
            mstatus_mie  <= n_mstatus[3];
            mstatus_mpie <= n_mstatus[7];
        end
    end

    // mepc -------------------------------------------
    assign wen_mepc = trap_any | wr.sel.mepc;
    assign n_mepc   = trap_any ? {trap.pc[`CSR_XLEN-1:1], 1'b0} :
        {csr_pkg::csr_combine(mepc, wr.wdata, wr.set, wr.clr)
            [`CSR_XLEN-1:1], 1'b0};
    assign mepc_fwd = wen_mepc ? n_mepc : mepc;    // Bypass the write cycle

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc <= '0;
        end else if (wen_mepc) begin
            mepc <= n_mepc;
        end
    end

    // mcause -----------------------------------------
    always_comb begin
        mcause_legal = 1'b0;
        if (wr.wdata[`CSR_XLEN-1:7] == '0) begin
            case (wr.wdata[6:0])
                csr_pkg::TRAP_IALIGN, csr_pkg::TRAP_IACCESS, csr_pkg::TRAP_IOPCODE,
                csr_pkg::TRAP_BREAKPT, csr_pkg::TRAP_LDALIGN, csr_pkg::TRAP_LDACCESS,
                csr_pkg::TRAP_STALIGN, csr_pkg::TRAP_STACCESS,
                csr_pkg::TRAP_ECALLM: mcause_legal = 1'b1;
                default:              mcause_legal = 1'b0;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcause <= '0;
        end else if (trap_any) begin
            mcause <= {trap.trap_int, {(`CSR_XLEN-8){1'b0}}, trap.cause};
        end else if (wr.sel.mcause && mcause_legal) begin
            mcause <= csr_pkg::csr_combine(mcause, wr.wdata, wr.set, wr.clr);
        end
    end

    // mtval ------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtval <= '0;
        end else if (trap.trap_int) begin
            mtval <= mtval;                  // Interrupts leave mtval alone
        end else if (trap.trap_cpu) begin
            mtval <= trap.mtval;
        end else if (wr.sel.mtval) begin
            mtval <= csr_pkg::csr_combine(mtval, wr.wdata, wr.set, wr.clr);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module csr_tb \
    -Mdir obj_dir

output=$(./obj_dir/Vcsr_tb)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// ==== verif/csr_stim.txt ====
# op addr data cause pc expected error (all hex)
# expected is csr_rdata for R and csr_mepc for W S C T I M
R 300 00000000 00 00000000 00000000 0
R 301 00000000 00 00000000 40001100 0
R 302 00000000 00 00000000 00000000 0
R 304 00000000 00 00000000 00000000 0
R 305 00000000 00 00000000 C0000000 0
R 340 00000000 00 00000000 00000000 0
R 341 00000000 00 00000000 00000000 0
R 342 00000000 00 00000000 00000000 0
R 343 00000000 00 00000000 00000000 0
R F11 00000000 00 00000000 00000000 0
R F14 00000000 00 00000000 00000000 0
W 340 12345678 00 00000000 00000000 0
S 340 0000F000 00 00000000 00000000 0
C 340 00000078 00 00000000 00000000 0
R 340 00000000 00 00000000 1234F600 0
W 304 FFFFFFFF 00 00000000 00000000 0
C 304 00000080 00 00000000 00000000 0
R 304 00000000 00 00000000 00000808 0
R 344 00000888 00 00000000 00000888 0
R 344 00000008 00 00000000 00000008 0
W 305 C0000002 00 00000000 00000000 1
W 305 00000041 00 00000000 00000000 1
R 305 00000000 00 00000000 C0000000 0
W 305 80000081 00 00000000 00000000 0
R 305 00000000 00 00000000 80000081 0
W 300 00000008 00 00000000 00000000 0
R 300 00000000 00 00000000 00000008 0
T 000 DEADBEEF 02 00001001 00001000 0
R 300 00000000 00 00000000 00000080 0
R 341 00000000 00 00000000 00001000 0
R 342 00000000 00 00000000 00000002 0
R 343 00000000 00 00000000 DEADBEEF 0
M 000 00000000 00 00000000 00001000 0
R 300 00000000 00 00000000 00000008 0
I 000 11111111 07 00002004 00002004 0
R 342 00000000 00 00000000 80000007 0
R 343 00000000 00 00000000 DEADBEEF 0
R 300 00000000 00 00000000 00000080 0
W 342 00000009 00 00000000 00002004 0
R 342 00000000 00 00000000 80000007 0
W 342 0000000B 00 00000000 00002004 0
R 342 00000000 00 00000000 0000000B 0
W 7C0 12345678 00 00000000 00002004 1
R 7C0 00000000 00 00000000 00000000 0
W 341 00003003 00 00000000 00003002 0
R 341 00000000 00 00000000 00003002 0

// ==== verif/csr_tb.sv ====
// Machine CSR block testbench
// Replays the stimulus table against csr_top and checks read data,
// forwarded mepc, the status outputs and the access error flag

`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_tb;

    localparam int MAX_OPS = 128;

    logic                    g_clk;
    logic                    g_resetn;
    logic                    csr_en;
    logic                    csr_wr;
    logic                    csr_wr_set;
    logic                    csr_wr_clr;
    logic [`CSR_ADDR_W-1:0]  csr_addr;
    logic [`CSR_XLEN-1:0]    csr_wdata;
    logic                    exec_mret;
    logic                    mip_meip;
    logic                    mip_mtip;
    logic                    mip_msip;
    logic                    trap_cpu;
    logic                    trap_int;
    logic [6:0]              trap_cause;
    logic [`CSR_XLEN-1:0]    trap_mtval;
    logic [`CSR_XLEN-1:0]    trap_pc;
    logic [`CSR_XLEN-1:0]    csr_rdata;
    logic                    csr_error;
    logic [`CSR_XLEN-1:0]    csr_mepc;
    logic [`CSR_XLEN-1:0]    mtvec_base;
    logic [1:0]              mtvec_mode;
    logic                    mstatus_mie;
    logic                    mie_meie;
    logic                    mie_mtie;
    logic                    mie_msie;

    // Stimulus table ---------------------------------
    logic [7:0]              op_code  [MAX_OPS];   // Operation letter
    logic [`CSR_ADDR_W-1:0]  op_addr  [MAX_OPS];
    logic [`CSR_XLEN-1:0]    op_data  [MAX_OPS];   // Write data, mtval or mip
    logic [6:0]              op_cause [MAX_OPS];
    logic [`CSR_XLEN-1:0]    op_pc    [MAX_OPS];
    logic [`CSR_XLEN-1:0]    op_exp   [MAX_OPS];   // Read data or csr_mepc
    logic                    op_err   [MAX_OPS];

    int n_ops;
    int errors;
    int fd;

    csr_top dut (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .csr_en      (csr_en),
        .csr_wr      (csr_wr),
        .csr_wr_set  (csr_wr_set),
        .csr_wr_clr  (csr_wr_clr),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .exec_mret   (exec_mret),
        .mip_meip    (mip_meip),
        .mip_mtip    (mip_mtip),
        .mip_msip    (mip_msip),
        .trap_cpu    (trap_cpu),
        .trap_int    (trap_int),
        .trap_cause  (trap_cause),
        .trap_mtval  (trap_mtval),
        .trap_pc     (trap_pc),
        .csr_rdata   (csr_rdata),
        .csr_error   (csr_error),
        .csr_mepc    (csr_mepc),
        .mtvec_base  (mtvec_base),
        .mtvec_mode  (mtvec_mode),
        .mstatus_mie (mstatus_mie),
        .mie_meie    (mie_meie),
        .mie_mtie    (mie_mtie),
        .mie_msie    (mie_msie)
    );

    always #2 g_clk = ~g_clk;   // 4 ns period

    task automatic idle_inputs();
        csr_en     = 1'b0;
        csr_wr     = 1'b0;
        csr_wr_set = 1'b0;
        csr_wr_clr = 1'b0;
        exec_mret  = 1'b0;
        trap_cpu   = 1'b0;
        trap_int   = 1'b0;
    endtask

    task automatic load_stimulus(input int file);
        logic [8*128-1:0] hdr;
        logic [7:0]       f_op;
        logic [31:0]      f_addr;
        logic [31:0]      f_data;
        logic [31:0]      f_cause;
        logic [31:0]      f_pc;
        logic [31:0]      f_exp;
        logic [31:0]      f_err;
        int               got;
        int               count;
        count = 0;
        got = $fgets(hdr, file);                    // Two column header lines
        got = $fgets(hdr, file);
        got = $fscanf(file, "%s %h %h %h %h %h %h",
                      f_op, f_addr, f_data, f_cause, f_pc, f_exp, f_err);
        while (got == 7 && count < MAX_OPS) begin
            op_code[count]  = f_op;
            op_addr[count]  = f_addr[`CSR_ADDR_W-1:0];
            op_data[count]  = f_data;
            op_cause[count] = f_cause[6:0];
            op_pc[count]    = f_pc;
            op_exp[count]   = f_exp;
            op_err[count]   = f_err[0];
            count++;
            got = $fscanf(file, "%s %h %h %h %h %h %h",
                          f_op, f_addr, f_data, f_cause, f_pc, f_exp, f_err);
        end
        n_ops = count;
    endtask

    task automatic drive_op(input int i);
        idle_inputs();
        csr_addr   = op_addr[i];
        csr_wdata  = op_data[i];
        trap_cause = op_cause[i];
        trap_mtval = op_data[i];
        trap_pc    = op_pc[i];
        case (op_code[i])
            "R": begin
                csr_en   = 1'b1;
                mip_meip = op_data[i][11];          // Pending bits ride on data
                mip_mtip = op_data[i][7];
                mip_msip = op_data[i][3];
            end
            "W": begin
                csr_en = 1'b1;
                csr_wr = 1'b1;
            end
            "S": begin
                csr_en     = 1'b1;
                csr_wr     = 1'b1;
                csr_wr_set = 1'b1;
            end
            "C": begin
                csr_en     = 1'b1;
                csr_wr     = 1'b1;
                csr_wr_clr = 1'b1;
            end
            "T": trap_cpu  = 1'b1;
            "I": trap_int  = 1'b1;
            "M": exec_mret = 1'b1;
            default: begin
                errors++;
                $display("Unknown operation letter in stimulus operation %0d", i + 1);
            end
        endcase
    endtask

    // Status outputs follow the register image just read
    task automatic compare_status_ports(input int i);
        case (op_addr[i])
            `CSR_ADDR_MSTATUS: begin
                assert (mstatus_mie == op_exp[i][3]) else begin
                    errors++;
                    $display("error %0t: op %0d mstatus_mie is %b, expected %b",
                             $time, i + 1, mstatus_mie, op_exp[i][3]);
                end
            end
            `CSR_ADDR_MIE: begin
                assert ({mie_meie, mie_mtie, mie_msie} ==
                        {op_exp[i][11], op_exp[i][7], op_exp[i][3]}) else begin
                    errors++;
                    $display("error %0t: op %0d mie outputs are %b%b%b, expected %b%b%b",
                             $time, i + 1, mie_meie, mie_mtie, mie_msie,
                             op_exp[i][11], op_exp[i][7], op_exp[i][3]);
                end
            end
            `CSR_ADDR_MTVEC: begin
                assert (mtvec_base == {op_exp[i][`CSR_XLEN-1:2], 2'b00} &&
                        mtvec_mode == op_exp[i][1:0]) else begin
                    errors++;
                    $display("error %0t: op %0d mtvec_base %h mode %0d, expected mtvec %h",
                             $time, i + 1, mtvec_base, mtvec_mode, op_exp[i]);
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_op(input int i);
        if (op_code[i] == "R") begin
            assert (csr_rdata == op_exp[i]) else begin
                errors++;
                $display("error %0t: op %0d read of %h returned %h, expected %h",
                         $time, i + 1, op_addr[i], csr_rdata, op_exp[i]);
            end
            compare_status_ports(i);
        end else begin
            assert (csr_mepc == op_exp[i]) else begin
                errors++;
                $display("error %0t: op %0d csr_mepc is %h, expected %h",
                         $time, i + 1, csr_mepc, op_exp[i]);
            end
        end
        assert (csr_error == op_err[i]) else begin
            errors++;
            $display("error %0t: op %0d csr_error is %b, expected %b",
                     $time, i + 1, csr_error, op_err[i]);
        end
    endtask

    // Watchdog ---------------------------------------
    initial begin
        wait (n_ops != 0);
        #(20 * n_ops);
        $display("Timeout: the stimulus did not finish in the allowed time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Main sequence ----------------------------------
    initial begin
        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        n_ops      = 0;
        errors     = 0;
        csr_addr   = '0;
        csr_wdata  = '0;
        trap_cause = '0;
        trap_mtval = '0;
        trap_pc    = '0;
        mip_meip   = 1'b0;
        mip_mtip   = 1'b0;
        mip_msip   = 1'b0;
        idle_inputs();
        fd = $fopen("verif/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/csr_stim.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            load_stimulus(fd);
            $fclose(fd);
            if (n_ops == 0) begin
                $display("The stimulus file holds no operations");
                $display("TESTBENCH FAILED");
                $finish;
            end else begin
                repeat (2) @(posedge g_clk);        // Two reset cycles
                @(negedge g_clk);
                g_resetn = 1'b1;
                for (int i = 0; i < n_ops; i++) begin
                    drive_op(i);
                    #1;                             // Just before the rising edge
                    check_op(i);
                    @(negedge g_clk);
                end
                idle_inputs();
                $display("Checks finished with %0d errors", errors);
                if (errors == 0) begin
                    $display("TESTBENCH PASSED");
                end else begin
                    $display("TESTBENCH FAILED");
                end
                $finish;
            end
        end
    end

endmodule
